/* tb/fetch_ip_stim.txt */
# code nb fz bm miss_ip mask pbr btgt0 btgt1 btgt2 insn0 insn1 insn2 valid take qcnt ra
# then expected branch_ip ip_override and after the edge ip ipd ip_maskd, all hex
# code 1 sequential step and freeze
1 1 0 0 0 7 0 0 0 0 0 0 0 0 0 0 0 ffffffff0100 0 ffffffff0110 ffffffff0100 7
1 1 0 0 0 3 0 0 0 0 0 0 0 0 0 0 0 ffffffff0100 0 ffffffff0120 ffffffff0110 3
1 1 1 0 0 5 0 0 0 0 0 0 0 0 0 0 0 ffffffff0110 0 ffffffff0120 ffffffff0120 5
1 0 0 0 0 7 0 0 0 0 0 0 0 0 0 0 0 ffffffff0120 0 ffffffff0120 ffffffff0120 5
# code 5 branch miss over override, prediction and freeze
5 1 1 1 2006 7 1 3000 0 0 40 0 0 1 0 1 4440 4440 1 2005 ffffffff0120 7
5 0 0 1 5abc 0 0 0 0 0 0 0 0 0 0 0 0 ffffffff0120 0 5abf ffffffff0120 7
# code 2 predicted targets, highest set slot wins
2 1 0 0 0 3 5 1000 1100 1204 0 0 0 0 0 0 0 ffffffff0120 0 1204 5abf 3
2 1 0 0 0 6 3 7000 7014 7f00 0 0 0 0 0 0 0 5abf 0 7014 1204 6
2 0 0 0 0 1 7 9000 9100 9200 0 0 0 0 0 0 0 1204 0 7014 1204 6
# code 3 return, jump-call and taken branch redirects
3 0 0 0 0 0 0 0 0 0 40 0 0 1 0 1 abcd0 abcd0 1 abcd0 1204 6
3 1 0 0 0 7 1 8880 0 0 0 48ca5 40 7 0 3 9990 12395 1 12395 abcd0 7
3 0 1 0 0 0 0 0 0 0 fff08000c0 fff08000c0 0 3 2 2 0 abbda 1 abbda abcd0 7
# code 4 slots outside the queued window or invalid
4 0 0 0 0 0 0 0 0 0 0 40 0 3 0 1 5555 abcd0 0 abbda abcd0 7
4 1 0 0 0 1 0 0 0 0 40 48ca5 0 4 0 3 5555 abcd0 0 abbe0 abbda 1
4 0 0 0 0 0 0 0 0 0 40 0 40 6 0 1 5555 abbda 0 abbe0 abbda 1
4 0 0 0 0 0 0 0 0 0 40 0 40 6 0 2 5555 5555 1 5555 abbda 1

/* sim.f */
src/insn_pkg.sv
src/fetch_pkg.sv
src/slot_predecode.sv
src/branch_redirect.sv
src/ip_sequencer.sv
src/fetch_ip_top.sv
tb/fetch_ip_sva.sv
tb/fetch_ip_tb.sv

/* Makefile */
# Verilator build and run of the fetch IP testbench

SIM      ?= verilator
TOP      ?= fetch_ip_tb
FILELIST ?= sim.f
OBJ_DIR  ?= obj_dir
VFLAGS   ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(SIM), run, and fail unless the pass message is printed"
	@echo "  clean  remove $(OBJ_DIR)"
	@echo "  help   show this list"

test:
	$(SIM) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o $(TOP)
	@out="$$(./$(OBJ_DIR)/$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TB PASSED"

clean:
	rm -rf $(OBJ_DIR)

/* tb/fetch_ip_tb.sv */
// reads one vector per line from the stimulus file and drives inputs 1 ns after the rising edge
// branch_ip and ip_override are sampled 2 ns before the next edge and registers 1 ns after it
`timescale 1ns/1ps
`default_nettype none

module fetch_ip_tb
	import fetch_pkg::*;
();

	localparam int MAX_LINES  = 200;
	localparam int RST_CYCLES = 10;
	localparam int RST_WAIT   = 50;

	logic              clk;
	logic              rst;
	logic              next_bundle;
	logic              freeze;
	logic              branch_miss;
	addr_t             miss_ip;
	logic [QSLOTS-1:0] ip_mask;
	pred_slot_t        pred [0:QSLOTS-1];
	fetch_slot_t       queue [0:QSLOTS-1];
	logic [1:0]        queued_cnt;
	addr_t             ra;
	addr_t             ip;
	addr_t             ipd;
	addr_t             branch_ip;
	logic [QSLOTS-1:0] ip_maskd;
	logic              ip_override;

	// current vector as read from the file
	logic [3:0]        code;
	logic              vec_nb, vec_fz, vec_bm, exp_ovr;
	logic [QSLOTS-1:0] vec_mask, vec_pbr, vec_valid, vec_take, exp_maskd;
	logic [1:0]        vec_qcnt;
	addr_t             vec_miss, vec_ra, exp_bip, exp_ip, exp_ipd;
	addr_t             vec_btgt [0:QSLOTS-1];
	logic [39:0]       vec_insn [0:QSLOTS-1];

	int                errors, checks, tests, vectors, test_checks, test_errors;
	logic [3:0]        cur_code;
	string             cur_name;

	fetch_ip_top fetch_ip_top_inst (
		.clk         (clk),
		.rst         (rst),
		.next_bundle (next_bundle),
		.freeze      (freeze),
		.branch_miss (branch_miss),
		.miss_ip     (miss_ip),
		.ip_mask     (ip_mask),
		.pred        (pred),
		.queue       (queue),
		.queued_cnt  (queued_cnt),
		.ra          (ra),
		.ip          (ip),
		.ipd         (ipd),
		.branch_ip   (branch_ip),
		.ip_maskd    (ip_maskd),
		.ip_override (ip_override)
	);

	bind ip_sequencer fetch_ip_sva fetch_ip_sva_inst (
		.clk         (clk),
		.rst         (rst),
		.next_bundle (next_bundle),
		.branch_miss (branch_miss),
		.ip          (ip),
		.ipd         (ipd)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial begin
		rst = 1'b1;
		repeat (RST_CYCLES) @(posedge clk);
		#1 rst = 1'b0;
	end

	// ========================================
	// helpers
	// ========================================
	function automatic string test_name(input logic [3:0] c);
		case (c)
			4'd1: return "step";
			4'd2: return "predict";
			4'd3: return "redirect";
			4'd4: return "ignored";
			4'd5: return "miss";
			default: return "unknown";
		endcase
	endfunction

	task automatic check_value(input string what, input addr_t expected, input addr_t actual);
		checks++;
		test_checks++;
		assert (actual === expected) else begin
			$display("CHECK FAILED %s %s expected %h actual %h", cur_name, what, expected, actual);
			errors++;
			test_errors++;
		end
	endtask

	task automatic report_test();
		$display("test %-9s %0d checks, %0d errors", cur_name, test_checks, test_errors);
		tests++;
		test_checks = 0;
		test_errors = 0;
	endtask

	task automatic drive_vector();
		next_bundle = vec_nb;
		freeze      = vec_fz;
		branch_miss = vec_bm;
		miss_ip     = vec_miss;
		ip_mask     = vec_mask;
		queued_cnt  = vec_qcnt;
		ra          = vec_ra;
		for (int i = 0; i < QSLOTS; i++) begin
			pred[i].br     = vec_pbr[i];
			pred[i].btgt   = vec_btgt[i];
			queue[i].insn  = vec_insn[i];
			queue[i].valid = vec_valid[i];
			queue[i].take  = vec_take[i];
		end
	endtask

	task automatic run_vector();
		drive_vector();
		#7;
		check_value("branch_ip", exp_bip, branch_ip);
		check_value("ip_override", addr_t'(exp_ovr), addr_t'(ip_override));
		@(posedge clk);
		#1;
		check_value("ip", exp_ip, ip);
		check_value("ipd", exp_ipd, ipd);
		check_value("ip_maskd", addr_t'(exp_maskd), addr_t'(ip_maskd));
		vectors++;
	endtask

	task automatic read_vectors(input int fd);
		int    n;
		int    lines;
		string line;
		lines = 0;
		while (!$feof(fd) && lines < MAX_LINES) begin
			n = $fgets(line, fd);
			lines++;
			if (n > 0 && line.getc(0) != "#") begin
				n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
					code, vec_nb, vec_fz, vec_bm, vec_miss, vec_mask, vec_pbr,
					vec_btgt[0], vec_btgt[1], vec_btgt[2], vec_insn[0], vec_insn[1], vec_insn[2],
					vec_valid, vec_take, vec_qcnt, vec_ra,
					exp_bip, exp_ovr, exp_ip, exp_ipd, exp_maskd);
				if (n == 22) begin
					// a new code starts the next test
					if (code != cur_code) begin
						if (test_checks > 0) begin
							report_test();
						end
						cur_code = code;
						cur_name = test_name(code);
					end
					run_vector();
				end else if (n > 0) begin
					$display("stimulus line %0d holds %0d fields instead of 22", lines, n);
					errors++;
				end
			end
		end
	endtask

	// ========================================
	// main sequence
	// ========================================
	initial begin
		int fd;
		int waited;
		vec_nb = 1'b0;
		vec_fz = 1'b0;
		vec_bm = 1'b0;
		vec_miss = '0;
		vec_mask = '0;
		vec_pbr = '0;
		vec_valid = '0;
		vec_take = '0;
		vec_qcnt = '0;
		vec_ra = '0;
		for (int i = 0; i < QSLOTS; i++) begin
			vec_btgt[i] = '0;
			vec_insn[i] = '0;
		end
		drive_vector();
		errors = 0;
		checks = 0;
		tests = 0;
		vectors = 0;
		test_checks = 0;
		test_errors = 0;
		cur_code = 4'd0;
		fd = $fopen("tb/fetch_ip_stim.txt", "r");
		waited = 0;
		while (rst !== 1'b0 && waited < RST_WAIT) begin
			@(negedge clk);
			waited++;
		end
		if (rst !== 1'b0 || fd == 0) begin
			if (rst !== 1'b0) begin
				$display("reset was never released");
			end else begin
				$display("could not open tb/fetch_ip_stim.txt");
			end
			$display("TB FAILED");
			$finish;
		end else begin
			@(posedge clk);
			#1;
			cur_name = "reset";
			check_value("ip", RST_IP, ip);
			check_value("ipd", RST_IP, ipd);
			check_value("ip_maskd", addr_t'(3'b111), addr_t'(ip_maskd));
			check_value("ip_override", '0, addr_t'(ip_override));
			report_test();
			read_vectors(fd);
			$fclose(fd);
			if (test_checks > 0) begin
				report_test();
			end
			if (vectors == 0) begin
				$display("no vectors were read from the stimulus file");
				errors++;
			end
			$display("%0d tests, %0d vectors, %0d checks, %0d errors",
				tests, vectors, checks, errors);
			if (errors == 0) begin
				$display("TB PASSED");
			end else begin
				$display("TB FAILED");
			end
			$finish;
		end
	end

endmodule

`default_nettype wire

/* tb/fetch_ip_sva.sv */
// register checks on the fetch address, bound into ip_sequencer
// checks past reset are disabled while rst is high
`timescale 1ns/1ps
`default_nettype none

module fetch_ip_sva
	import fetch_pkg::*;
(
	input logic  clk,
	input logic  rst,
	input logic  next_bundle,
	input logic  branch_miss,
	input addr_t ip,
	input addr_t ipd
);

	// reset lands on the boot address
	a_reset_ip: assert property (@(posedge clk) rst |=> (ip == RST_IP))
		else $error("ip is not the reset address after reset");

	// a miss rebuilds the low nibble from the slot field
	a_miss_nibble: assert property (@(posedge clk) disable iff (rst)
		branch_miss |=> (ip[3:0] == {ip[3:2], ip[3:2]}))
		else $error("ip low nibble after a branch miss is not bits [3:2] twice");

	// delayed address only moves with an accepted bundle
	a_ipd_hold: assert property (@(posedge clk) disable iff (rst)
		!next_bundle |=> $stable(ipd))
		else $error("ipd changed without next_bundle");

endmodule

`default_nettype wire

/* src/fetch_ip_top.sv */
// fetch instruction pointer unit, one register stage
// predictor, return stack and queue live outside, all inputs are plain strobes
`timescale 1ns/1ps
`default_nettype none

module fetch_ip_top
	import fetch_pkg::*;
(
	input  logic              clk,
	input  logic              rst,
	input  logic              next_bundle,
	input  logic              freeze,
	input  logic              branch_miss,
	input  addr_t             miss_ip,
	input  logic [QSLOTS-1:0] ip_mask,
	input  pred_slot_t        pred [0:QSLOTS-1],
	input  fetch_slot_t       queue [0:QSLOTS-1],
	input  logic [1:0]        queued_cnt,
	input  addr_t             ra,
	output addr_t             ip,
	output addr_t             ipd,
	output addr_t             branch_ip,
	output logic [QSLOTS-1:0] ip_maskd,
	output logic              ip_override
);

	flow_t             flow [0:QSLOTS-1];
	logic [QSLOTS-1:0] slot_valid;

	// one predecoder per queued slot
	for (genvar i = 0; i < QSLOTS; i++) begin : g_slot
		assign slot_valid[i] = queue[i].valid;

		slot_predecode slot_predecode_inst (
			.slot (queue[i]),
			.ipd  (ipd),
			.flow (flow[i])
		);
	end

	branch_redirect branch_redirect_inst (
		.rst         (rst),
		.flow        (flow),
		.valid       (slot_valid),
		.queued_cnt  (queued_cnt),
		.ipd         (ipd),
		.ra          (ra),
		.branch_ip   (branch_ip),
		.ip_override (ip_override)
	);

	ip_sequencer ip_sequencer_inst (
		.clk         (clk),
		.rst         (rst),
		.next_bundle (next_bundle),
		.freeze      (freeze),
		.branch_miss (branch_miss),
		.miss_ip     (miss_ip),
		.ip_mask     (ip_mask),
		.pred        (pred),
		.branch_ip   (branch_ip),
		.ip_override (ip_override),
		.ip          (ip),
		.ipd         (ipd),
		.ip_maskd    (ip_maskd)
	);

endmodule

`default_nettype wire

/* src/ip_sequencer.sv */
// fetch address register and next-address priority
// priority is branch miss, then predecode override, then sequential or predicted advance
`timescale 1ns/1ps
`default_nettype none

module ip_sequencer
	import fetch_pkg::*;
(
	input  logic              clk,
	input  logic              rst,
	input  logic              next_bundle,
	input  logic              freeze,
	input  logic              branch_miss,
	input  addr_t             miss_ip,
	input  logic [QSLOTS-1:0] ip_mask,
	input  pred_slot_t        pred [0:QSLOTS-1],
	input  addr_t             branch_ip,
	input  logic              ip_override,
	output addr_t             ip,
	output addr_t             ipd,
	output logic [QSLOTS-1:0] ip_maskd
);

	addr_t adv_ip;
	addr_t miss_tgt;
	addr_t next_ip;

	// ========================================
	// next fetch address
	// ========================================

	// low nibble rebuilt from the slot field of the miss address
	assign miss_tgt = {miss_ip[ADDR_W-1:BUNDLE_SHIFT], miss_ip[3:2], miss_ip[3:2]};

	always_comb begin
		adv_ip = {ip[ADDR_W-1:BUNDLE_SHIFT] + BUNDLE_W'(1), {BUNDLE_SHIFT{1'b0}}};
		// highest predicted slot wins
		for (int i = 0; i < QSLOTS; i++) begin
			if (pred[i].br) begin
				adv_ip = pred[i].btgt;
			end
		end
	end

	always_comb begin
		if (branch_miss) begin
			next_ip = miss_tgt;
		end else if (ip_override) begin
			next_ip = branch_ip;
		end else if (next_bundle && !freeze) begin
			next_ip = adv_ip;
		end else begin
			next_ip = ip;
		end
	end

	// ========================================
	// registers
	// ========================================
	always_ff @(posedge clk) begin
		if (rst) begin
			ip       <= RST_IP;
			ipd      <= RST_IP;
			ip_maskd <= '1;
		end else begin
			ip <= next_ip;
			// delayed copy tracks the bundle handed to the queue, freeze or not
			if (next_bundle) begin
				ipd      <= ip;
				ip_maskd <= ip_mask;
			end
		end
	end

endmodule

`default_nettype wire

/* src/branch_redirect.sv */
// picks the first redirecting slot among the queued valid slots
// queued_cnt counts valid slots from slot 0 upward, later valid slots are not yet queued
`timescale 1ns/1ps
`default_nettype none

module branch_redirect
	import fetch_pkg::*;
(
	input  logic              rst,
	input  flow_t             flow [0:QSLOTS-1],
	input  logic [QSLOTS-1:0] valid,
	input  logic [1:0]        queued_cnt,
	input  addr_t             ipd,
	input  addr_t             ra,
	output addr_t             branch_ip,
	output logic              ip_override
);

	addr_t      sel_ip;
	logic       hit;
	logic [1:0] seen;

	// ========================================
	// slot scan
	// ========================================
	always_comb begin
		sel_ip = ipd;
		hit    = 1'b0;
		seen   = 2'd0;
		for (int i = 0; i < QSLOTS; i++) begin
			// only slots inside the queued window count
			if (valid[i] && !hit && (seen < queued_cnt)) begin
				if (flow[i].ret) begin
					sel_ip = ra;
					hit    = 1'b1;
				end else if (flow[i].jc || flow[i].br_taken) begin
					// predecode already picked jc over branch target
					sel_ip = flow[i].target;
					hit    = 1'b1;
				end
			end
			if (valid[i]) begin
				seen = seen + 2'd1;
			end
		end
	end

	assign branch_ip = rst ? RST_IP : sel_ip;

	// any difference from the queued bundle address means fetch went the wrong way
	assign ip_override = (branch_ip != ipd);

endmodule

`default_nettype wire

/* src/slot_predecode.sv */
// predecodes one queued slot, purely combinational
// target is meaningless for a return, the return stack supplies it
`timescale 1ns/1ps
`default_nettype none

module slot_predecode
	import fetch_pkg::*, insn_pkg::*;
(
	input  fetch_slot_t slot,
	input  addr_t       ipd,
	output flow_t       flow
);

	logic [OPC_W-1:0] opcode;
	addr_t            jc_tgt;
	addr_t            br_tgt;
	logic [BUNDLE_W-1:0] disp_ext;

	// both views share the opcode field
	assign opcode = slot.insn.br_form.opcode;

	// jump-call keeps the upper page of ipd
	assign jc_tgt = {ipd[ADDR_W-1:JC_W],
		slot.insn.jc_form.tgt_hi,
		slot.insn.jc_form.tgt_lo,
		slot.insn.jc_form.tgt_lo[1:0]};

	assign disp_ext = {{(BUNDLE_W-DISP_W){slot.insn.br_form.disp[DISP_W-1]}},
		slot.insn.br_form.disp};

	// displacement counts bundles, slot number lands in the low nibble
	assign br_tgt = {ipd[ADDR_W-1:BUNDLE_SHIFT] + disp_ext,
		slot.insn.br_form.slot,
		slot.insn.br_form.slot};

	always_comb begin
		flow.ret      = (opcode == OP_RET);
		flow.jc       = (opcode == OP_JC);
		flow.br_taken = (opcode == OP_BRANCH) && slot.take;
		if (opcode == OP_JC) begin
			flow.target = jc_tgt;
		end else begin
			flow.target = br_tgt;
		end
	end

endmodule

`default_nettype wire

/* src/fetch_pkg.sv */
// fetch address geometry and the per-slot records passed between fetch blocks
// bundles are 16 bytes with three 40-bit slots, addresses are 48 bits
`default_nettype none

package fetch_pkg;

	import insn_pkg::*;

	// ========================================
	// geometry
	// ========================================
	localparam int ADDR_W       = 48;
	localparam int QSLOTS       = 3;
	localparam int BUNDLE_SHIFT = 4;
	localparam int BUNDLE_W     = ADDR_W - BUNDLE_SHIFT;
	// low address bits replaced by a jump-call
	localparam int JC_W         = 38;

	localparam logic [ADDR_W-1:0] RST_IP = 48'hFFFF_FFFF_0100;

	typedef logic [ADDR_W-1:0] addr_t;

	// ========================================
	// slot records
	// ========================================

	// one slot of the bundle now queued
	typedef struct packed {
		insn_word_u insn;
		logic       valid;
		logic       take;
	} fetch_slot_t;

	// predictor output for one slot of the current bundle
	typedef struct packed {
		logic  br;
		addr_t btgt;
	} pred_slot_t;

	// predecode result for one slot
	typedef struct packed {
		logic  ret;
		logic  jc;
		logic  br_taken;
		addr_t target;
	} flow_t;

endpackage

`default_nettype wire

/* src/insn_pkg.sv */
// instruction word layout as seen by fetch predecode
// the opcode sits at [9:6] in both views, codes other than the three below are plain
`default_nettype none

package insn_pkg;

	localparam int OPC_W  = 4;
	localparam int DISP_W = 16;

	// opcodes that change the flow of fetch
	localparam logic [OPC_W-1:0] OP_RET    = 4'd1;
	localparam logic [OPC_W-1:0] OP_JC     = 4'd2;
	localparam logic [OPC_W-1:0] OP_BRANCH = 4'd3;

	// conditional branch view
	typedef struct packed {
		logic [DISP_W-1:0] disp;
		logic [1:0]        slot;
		logic [11:0]       rsv_hi;
		logic [OPC_W-1:0]  opcode;
		logic [5:0]        rsv_lo;
	} br_form_t;

	// jump-call view, target bits wrap around the opcode
	typedef struct packed {
		logic [29:0]      tgt_hi;
		logic [OPC_W-1:0] opcode;
		logic [5:0]       tgt_lo;
	} jc_form_t;

	typedef union packed {
		br_form_t br_form;
		jc_form_t jc_form;
	} insn_word_u;

endpackage

`default_nettype wire
